// ==== hw/vgc_timing_pkg.sv ====
`default_nettype none

package vgc_timing_pkg;

    // Active window in beam coordinates, end values are one past the last
    localparam logic [9:0] H_ACTIVE_START = 10'd32;
    localparam logic [9:0] H_ACTIVE_END   = 10'd672;
    localparam logic [8:0] V_ACTIVE_START = 9'd32;
    localparam logic [8:0] V_ACTIVE_END   = 9'd232;

    // Vertical-blank interrupt line
    localparam logic [8:0] V_BLANK_LINE = 9'd199;

    // h_count values per line, 0 to 911
    localparam logic [9:0] H_TOTAL = 10'd912;

    // A fetch is decided this many cycles before its address is on the bus
    localparam logic [9:0] FETCH_LEAD = 10'd2;

    // SCB address shows on video_addr on this h_count
    localparam logic [9:0] H_SCB_FETCH = 10'd905;

    // Palette bytes per line and bytes per stored palette
    localparam logic [5:0] PALETTE_BYTES  = 6'd32;
    localparam logic [5:0] PALETTE_STRIDE = 6'd32;

    // SHR memory map
    localparam logic [22:0] SCB_BASE     = 23'h19D00;
    localparam logic [22:0] PALETTE_BASE = 23'h19E00;
    localparam logic [22:0] PIXEL_BASE   = 23'h12000;
    localparam logic [7:0]  LINE_BYTES   = 8'd160;

    typedef enum logic [1:0] {
        IDLE,
        SCB,
        PALETTE,
        PIXEL
    } fetch_phase_e;

    // One fetch request, valid the cycle before its address appears
    typedef struct packed {
        fetch_phase_e phase;
        // Palette byte 0-31 or pixel byte 0-159
        logic [7:0]   step;
        // Index of the line the fetch is for
        logic [7:0]   line;
    } seq_cmd_t;

endpackage

`default_nettype wire

// ==== hw/vgc_color_pkg.sv ====
`default_nettype none

package vgc_color_pkg;

    // Scanline control byte
    typedef struct packed {
        logic       mode_640;
        logic       irq_en;
        logic       fill_en;
        logic       reserved;
        logic [3:0] palette_sel;
    } scb_t;

    // Pixel byte, read as nibbles in 320 mode or crumbs in 640 mode
    // Highest index is the leftmost pixel in both views
    typedef union packed {
        logic [1:0][3:0] nibble;
        logic [3:0][1:0] crumb;
    } pixel_byte_u;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb24_t;

    // Standard IIgs colors, used for the border
    localparam rgb12_t BORDER_PALETTE [0:15] = '{
        12'h000,
        12'hd03,
        12'h009,
        12'hd2d,
        12'h072,
        12'h555,
        12'h22f,
        12'h6af,
        // Brown, orange, light gray, pink
        12'h850,
        12'hf60,
        12'haaa,
        12'hf98,
        // Light green, yellow, aqua, white
        12'h1d0,
        12'hff0,
        12'h4f9,
        12'hfff
    };

endpackage

`default_nettype wire

// ==== hw/shr_line_sequencer.sv ====
`default_nettype none

module shr_line_sequencer
    import vgc_timing_pkg::*;
(
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_count,
    input  wire logic [8:0] v_count,
    output seq_cmd_t        seq_cmd,
    input  wire logic       scb_irq_en,
    output logic            scanline_irq
);

    seq_cmd_t   next_cmd;
    logic       cur_active;
    logic       next_active;
    logic [7:0] cur_line;
    logic [7:0] next_line;
    logic [9:0] pix_offset;
    logic       pix_slot;
    // Shift of the SCB request, stage 1 marks the cycle after the latch
    logic [1:0] scb_stage;

    assign cur_active  = (v_count >= V_ACTIVE_START) && (v_count < V_ACTIVE_END);
    assign next_active = (v_count >= V_ACTIVE_START - 9'd1) && (v_count < V_ACTIVE_END - 9'd1);
    assign cur_line    = 8'(v_count - V_ACTIVE_START);
    assign next_line   = 8'(v_count - V_ACTIVE_START + 9'd1);

    // Pixel byte j is decided at h_count 29 + 4j, so its address lands on 31 + 4j
    assign pix_offset = h_count - (H_ACTIVE_START - FETCH_LEAD - 10'd1);
    assign pix_slot   = (h_count >= H_ACTIVE_START - FETCH_LEAD - 10'd1)
                        && (pix_offset[1:0] == 2'd0)
                        && (pix_offset[9:2] < LINE_BYTES);

    always_comb begin
        next_cmd       = seq_cmd;
        next_cmd.phase = IDLE;
        // Palette runs as one burst of 32 steps and may cross the line wrap
        if (seq_cmd.phase == PALETTE && seq_cmd.step != 8'(PALETTE_BYTES - 6'd1)) begin
            next_cmd.phase = PALETTE;
            next_cmd.step  = seq_cmd.step + 8'd1;
        end else if (h_count == H_SCB_FETCH - FETCH_LEAD && next_active) begin
            next_cmd = '{phase: SCB, step: 8'd0, line: next_line};
        end else if (h_count == H_TOTAL - FETCH_LEAD - 10'd1 && next_active) begin
            // Burst starts one slot early, its last byte clears the first pixel fetch
            next_cmd = '{phase: PALETTE, step: 8'd0, line: next_line};
        end else if (pix_slot && cur_active) begin
            next_cmd = '{phase: PIXEL, step: pix_offset[9:2], line: cur_line};
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            seq_cmd   <= '{phase: IDLE, step: 8'd0, line: 8'd0};
            scb_stage <= 2'b00;
        end else if (ce_pix) begin
            seq_cmd   <= next_cmd;
            scb_stage <= {scb_stage[0], seq_cmd.phase == SCB};
        end
    end

    // New SCB is held by the decoder from the cycle after its fetch
    assign scanline_irq = scb_stage[1] && scb_irq_en;

endmodule

`default_nettype wire

// ==== hw/shr_fetch_addr_counter.sv ====
`default_nettype none

module shr_fetch_addr_counter
    import vgc_timing_pkg::*;
(
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire seq_cmd_t   seq_cmd,
    input  wire logic [3:0] palette_sel,
    output logic [22:0]     video_addr
);

    logic [22:0] line_ext;
    logic [22:0] palette_start;
    logic [22:0] pixel_start;
    logic        first_step;

    assign line_ext   = 23'(seq_cmd.line);
    assign first_step = (seq_cmd.step == 8'd0);

    // Palettes sit back to back, one stride each
    assign palette_start = PALETTE_BASE + (23'(palette_sel) << $clog2(PALETTE_STRIDE));

    // Line base times 160 as 128 + 32
    assign pixel_start = PIXEL_BASE + (line_ext << 7) + (line_ext << 5);

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            video_addr <= 23'd0;
        end else if (ce_pix) begin
            case (seq_cmd.phase)
                SCB: begin
                    video_addr <= SCB_BASE + line_ext;
                end
                PALETTE: begin
                    if (first_step) begin
                        video_addr <= palette_start;
                    end else begin
                        video_addr <= video_addr + 23'd1;
                    end
                end
                PIXEL: begin
                    // Later bytes follow on from the previous address
                    if (first_step) begin
                        video_addr <= pixel_start;
                    end else begin
                        video_addr <= video_addr + 23'd1;
                    end
                end
                default: begin
                    // Hold the last address between fetches
                    video_addr <= video_addr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/shr_palette_ram.sv ====
`default_nettype none

module shr_palette_ram
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
(
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire seq_cmd_t   seq_cmd,
    input  wire logic [7:0] video_data,
    input  wire logic [3:0] pal_index,
    output rgb12_t          pal_color
);

    rgb12_t   entries [0:15];
    // Request of the previous cycle, tells which byte is on video_data now
    seq_cmd_t data_cmd;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            data_cmd <= '{phase: IDLE, step: 8'd0, line: 8'd0};
            for (int i = 0; i < 16; i++) begin
                entries[i] <= '0;
            end
        end else if (ce_pix) begin
            data_cmd <= seq_cmd;
            if (data_cmd.phase == PALETTE) begin
                // Even byte carries green and blue, odd byte carries red
                if (!data_cmd.step[0]) begin
                    entries[data_cmd.step[4:1]].g <= video_data[7:4];
                    entries[data_cmd.step[4:1]].b <= video_data[3:0];
                end else begin
                    entries[data_cmd.step[4:1]].r <= video_data[3:0];
                end
            end
        end
    end

    assign pal_color = entries[pal_index];

endmodule

`default_nettype wire

// ==== hw/shr_pixel_decoder.sv ====
`default_nettype none

module shr_pixel_decoder
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
(
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire seq_cmd_t   seq_cmd,
    input  wire logic [7:0] video_data,
    output logic [3:0]      palette_sel,
    output logic            scb_irq_en,
    output logic [3:0]      pal_index
);

    seq_cmd_t    data_cmd;
    scb_t        scb;
    pixel_byte_u pix_byte;
    // Position within the current byte, 0 on the first pixel
    logic [1:0]  pos;
    // Last nonzero nibble seen on this line, for fill mode
    logic [3:0]  last_nz;
    logic [3:0]  nibble;

    assign palette_sel = scb.palette_sel;
    assign scb_irq_en  = scb.irq_en;

    always_comb begin
        // Positions 0 and 1 take the high nibble, 2 and 3 the low one
        nibble = pix_byte.nibble[~pos[1]];
        if (scb.mode_640) begin
            // Crumb m maps to 8+c, 12+c, c, 4+c
            pal_index = {~pos[1], pos[0], pix_byte.crumb[~pos]};
        end else if (scb.fill_en && nibble == 4'd0) begin
            pal_index = last_nz;
        end else begin
            pal_index = nibble;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            data_cmd <= '{phase: IDLE, step: 8'd0, line: 8'd0};
            scb      <= '0;
            pos      <= 2'd0;
            last_nz  <= 4'd0;
        end else if (ce_pix) begin
            data_cmd <= seq_cmd;
            if (data_cmd.phase == SCB) begin
                scb <= video_data;
            end
            // Restart the position count with each new byte
            if (data_cmd.phase == PIXEL) begin
                pos <= 2'd0;
            end else begin
                pos <= pos + 2'd1;
            end
            // Fill memory starts clear on every line
            if (data_cmd.phase == PIXEL && data_cmd.step == 8'd0) begin
                last_nz <= 4'd0;
            end else if (nibble != 4'd0) begin
                last_nz <= nibble;
            end
        end
    end

    // Pixel byte, loaded from the bus in the cycle its address was shown
    always_ff @(posedge clk_vid) begin
        if (ce_pix && data_cmd.phase == PIXEL) begin
            pix_byte <= video_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/shr_video_output.sv ====
`default_nettype none

module shr_video_output
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
(
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_count,
    input  wire logic [8:0] v_count,
    input  wire logic [3:0] border_color,
    input  wire rgb12_t     pal_color,
    output rgb24_t          rgb,
    output logic            vbl_irq
);

    logic   in_window;
    rgb12_t color;
    logic   v_blank;
    // Blank state of the previous cycle
    logic   v_blank_d;

    // 4-bit channels fill the full 8-bit range by repeating the nibble
    function automatic rgb24_t double_nibbles(rgb12_t c);
        return '{r: {c.r, c.r}, g: {c.g, c.g}, b: {c.b, c.b}};
    endfunction

    assign in_window = (h_count >= H_ACTIVE_START) && (h_count < H_ACTIVE_END)
                       && (v_count >= V_ACTIVE_START) && (v_count < V_ACTIVE_END);

    assign color = in_window ? pal_color : BORDER_PALETTE[border_color];

    // Beam position shows on rgb one cycle later
    always_ff @(posedge clk_vid) begin
        if (reset) begin
            rgb <= '0;
        end else if (ce_pix) begin
            rgb <= double_nibbles(color);
        end
    end

    assign v_blank = (v_count >= V_BLANK_LINE);

    // Starts set so no pulse fires until a line above the blank is seen
    always_ff @(posedge clk_vid) begin
        if (reset) begin
            v_blank_d <= 1'b1;
        end else if (ce_pix) begin
            v_blank_d <= v_blank;
        end
    end

    // Single pulse on entry to the blank region
    assign vbl_irq = v_blank && !v_blank_d;

endmodule

`default_nettype wire

// ==== hw/vgc_shr_top.sv ====
`default_nettype none

module vgc_shr_top
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
(
    input  wire logic        clk_vid,
    input  wire logic        reset,
    input  wire logic        ce_pix,
    input  wire logic [9:0]  h_count,
    input  wire logic [8:0]  v_count,
    input  wire logic [3:0]  border_color,
    input  wire logic [7:0]  video_data,
    output logic      [22:0] video_addr,
    output rgb24_t           rgb,
    output logic             scanline_irq,
    output logic             vbl_irq
);

    seq_cmd_t   seq_cmd;
    logic [3:0] palette_sel;
    logic       scb_irq_en;
    logic [3:0] pal_index;
    rgb12_t     pal_color;

    // Beam position to fetch requests and scanline interrupt
    shr_line_sequencer u_sequencer (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .seq_cmd      (seq_cmd),
        .scb_irq_en   (scb_irq_en),
        .scanline_irq (scanline_irq)
    );

    shr_fetch_addr_counter u_addr_counter (
        .clk_vid     (clk_vid),
        .reset       (reset),
        .ce_pix      (ce_pix),
        .seq_cmd     (seq_cmd),
        .palette_sel (palette_sel),
        .video_addr  (video_addr)
    );

    shr_palette_ram u_palette (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .seq_cmd    (seq_cmd),
        .video_data (video_data),
        .pal_index  (pal_index),
        .pal_color  (pal_color)
    );

    // Holds the SCB, so all mode decisions live here
    shr_pixel_decoder u_decoder (
        .clk_vid     (clk_vid),
        .reset       (reset),
        .ce_pix      (ce_pix),
        .seq_cmd     (seq_cmd),
        .video_data  (video_data),
        .palette_sel (palette_sel),
        .scb_irq_en  (scb_irq_en),
        .pal_index   (pal_index)
    );

    shr_video_output u_output (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .border_color (border_color),
        .pal_color    (pal_color),
        .rgb          (rgb),
        .vbl_irq      (vbl_irq)
    );

endmodule

`default_nettype wire

// ==== tests/vgc_shr_asserts.sv ====
`default_nettype none

module vgc_shr_asserts (
    input wire logic        clk_vid,
    input wire logic        reset,
    input wire logic        ce_pix,
    input wire logic        scanline_irq,
    input wire logic        vbl_irq,
    input wire logic [23:0] rgb
);

    timeunit 1ns;
    timeprecision 100ps;

    // Interrupt levels seen on the previous ce_pix cycle
    logic scan_prev;
    logic vbl_prev;
    // Failures seen so far
    int   fail_count = 0;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            scan_prev <= 1'b0;
            vbl_prev  <= 1'b0;
        end else if (ce_pix) begin
            scan_prev <= scanline_irq;
            vbl_prev  <= vbl_irq;
        end
    end

    // A pulse never spans two ce_pix cycles
    scan_one_cycle: assert property (@(posedge clk_vid) disable iff (reset)
        (ce_pix && scan_prev) |-> !scanline_irq)
        else begin
            $error("scanline_irq held for more than one ce_pix cycle");
            fail_count++;
        end

    vbl_one_cycle: assert property (@(posedge clk_vid) disable iff (reset)
        (ce_pix && vbl_prev) |-> !vbl_irq)
        else begin
            $error("vbl_irq held for more than one ce_pix cycle");
            fail_count++;
        end

    // Output register clears under reset
    rgb_reset_zero: assert property (@(posedge clk_vid)
        (reset && $past(reset)) |-> (rgb == 24'h0))
        else begin
            $error("rgb not zero during reset");
            fail_count++;
        end

endmodule

bind vgc_shr_top vgc_shr_asserts u_asserts (
    .clk_vid      (clk_vid),
    .reset        (reset),
    .ce_pix       (ce_pix),
    .scanline_irq (scanline_irq),
    .vbl_irq      (vbl_irq),
    .rgb          (rgb)
);

`default_nettype wire

// ==== tests/tb_vgc_shr.sv ====
`default_nettype none

module tb_vgc_shr
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_vid;
    logic        reset;
    logic        ce_pix;
    logic [9:0]  h_count;
    logic [8:0]  v_count;
    logic [3:0]  border_color;
    logic [7:0]  video_data;
    logic [22:0] video_addr;
    rgb24_t      rgb;
    logic        scanline_irq;
    logic        vbl_irq;

    // Memory image, expected colors keyed by v*1024+h, border color per line
    logic [7:0]  mem [logic [22:0]];
    logic [23:0] expect_rgb [int];
    logic [3:0]  border_at [int];
    // Lines run in order, each one from h_count 0 to 911
    int          run_lines [9] = '{30, 31, 32, 33, 34, 197, 198, 199, 200};
    logic [31:0] lfsr;
    logic        below_seen;
    int          record_hits;
    int          vbl_pulses;

    vgc_shr_top dut (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .rgb          (rgb),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    initial begin
        clk_vid = 1'b0;
        forever #10 clk_vid = ~clk_vid;
    end

    // Watchdog for the whole run
    initial begin
        #2ms;
        $display("Error: simulation ran past its time limit");
        abort_run();
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Error: %s = %h, expected %h", name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // Unwritten bytes read as zero
    function automatic logic [7:0] mem_read(input logic [22:0] addr);
        return mem.exists(addr) ? mem[addr] : 8'h00;
    endfunction

    // Each 4-bit channel repeated to fill 8 bits
    function automatic logic [23:0] widen_color(input rgb12_t c);
        return {c.r, c.r, c.g, c.g, c.b, c.b};
    endfunction

    function automatic logic is_border(input logic [8:0] v, input logic [9:0] h);
        return (h < 10'd32) || (h >= 10'd672) || (v < 9'd32) || (v >= 9'd232);
    endfunction

    // Pulse follows the SCB fetch of an active next line with irq_en set
    function automatic logic scan_expected(input logic [8:0] v, input logic [9:0] h);
        logic [8:0] nxt;
        logic [7:0] scb_byte;
        nxt = v + 9'd1;
        if (h != H_SCB_FETCH || nxt < 9'd32 || nxt >= 9'd232) begin
            return 1'b0;
        end
        scb_byte = mem_read(SCB_BASE + 23'(nxt - 9'd32));
        return scb_byte[6];
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("tests/vgc_shr_vectors.txt", "r");
        if (fd == 0) begin
            report_problem("could not open tests/vgc_shr_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // Skip blank lines and comments
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
                case (tag)
                    "M": mem[a[22:0]] = b[7:0];
                    "B": border_at[int'(a)] = b[3:0];
                    "E": expect_rgb[int'(a) * 1024 + int'(b)] = c[23:0];
                    default: report_problem("unknown record in vector file");
                endcase
            end
        end
        $fclose(fd);
    endtask

    // Present one beam position until a ce_pix cycle takes it, then check outputs
    task automatic present_position(input logic [8:0] v, input logic [9:0] h);
        int          gap;
        logic        taken;
        logic        b0;
        logic        b1;
        logic        vbl_want;
        logic        scan_want;
        logic [23:0] rgb_want;
        int          key;
        gap   = 0;
        taken = 1'b0;
        key   = int'(v) * 1024 + int'(h);
        while (!taken) begin
            v_count = v;
            h_count = h;
            // About one cycle in four idles, never more than four in a row
            if (gap >= 4) begin
                ce_pix = 1'b1;
            end else begin
                b0     = take_bit();
                b1     = take_bit();
                ce_pix = !(b0 && b1);
            end
            #1;
            vbl_want = (v >= 9'd199) && below_seen;
            assert (vbl_irq == vbl_want)
                else report_mismatch("vbl_irq", 32'(vbl_irq), 32'(vbl_want));
            if (ce_pix && vbl_irq) begin
                vbl_pulses++;
            end
            @(posedge clk_vid);
            taken = ce_pix;
            @(negedge clk_vid);
            // Memory answers from the address of this cycle
            video_data = mem_read(video_addr);
            gap++;
            if (gap > 16) begin
                report_problem("ce_pix stayed low too long");
            end
        end
        below_seen = (v < 9'd199);
        scan_want  = scan_expected(v, h);
        assert (scanline_irq == scan_want)
            else report_mismatch("scanline_irq", 32'(scanline_irq), 32'(scan_want));
        if (is_border(v, h)) begin
            rgb_want = widen_color(BORDER_PALETTE[border_color]);
            assert (rgb == rgb_want)
                else report_mismatch("rgb", 32'(rgb), 32'(rgb_want));
        end else if (expect_rgb.exists(key)) begin
            record_hits++;
            assert (rgb == expect_rgb[key])
                else report_mismatch("rgb", 32'(rgb), 32'(expect_rgb[key]));
        end
    endtask

    initial begin
        int i;
        int h;
        reset        = 1'b1;
        ce_pix       = 1'b0;
        h_count      = 10'd0;
        v_count      = 9'd0;
        border_color = 4'd0;
        video_data   = 8'h00;
        lfsr         = 32'h73c;
        below_seen   = 1'b0;
        record_hits  = 0;
        vbl_pulses   = 0;
        load_vectors();

        for (i = 0; i < 5; i++) begin
            @(posedge clk_vid);
        end
        @(negedge clk_vid);
        // Outputs cleared before any ce_pix cycle
        assert (rgb == 24'h0) else report_mismatch("rgb", 32'(rgb), 32'h0);
        assert (video_addr == 23'h0)
            else report_mismatch("video_addr", 32'(video_addr), 32'h0);
        assert (scanline_irq == 1'b0)
            else report_mismatch("scanline_irq", 32'(scanline_irq), 32'h0);
        assert (vbl_irq == 1'b0) else report_mismatch("vbl_irq", 32'(vbl_irq), 32'h0);
        reset      = 1'b0;
        video_data = mem_read(video_addr);

        for (i = 0; i < 9; i++) begin
            if (border_at.exists(run_lines[i])) begin
                border_color = border_at[run_lines[i]];
            end
            for (h = 0; h < 912; h++) begin
                present_position(9'(run_lines[i]), 10'(h));
            end
        end

        assert (record_hits == expect_rgb.num())
            else report_problem("some expected color records were never reached");
        assert (vbl_pulses == 1)
            else report_mismatch("vbl_irq pulse count", 32'(vbl_pulses), 32'd1);

        if (dut.u_asserts.fail_count != 0) begin
            report_problem("a bound concurrent assertion failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/vgc_shr_vectors.txt ====
# M addr data | B v_count border_color | E v_count h_count rgb (all hex)
# Lines 0 to 2: 320 palette 1, 320 fill palette 0, 640 palette 0
B 1e 6
B 21 9
M 19d00 41
M 19d01 20
M 19d02 c0
M 19e26 23
M 19e27 01
M 19e2a bc
M 19e2b fa
M 19e04 56
M 19e05 04
M 19e0e ef
M 19e0f 0d
M 19e10 11
M 19e11 01
M 19e1a 34
M 19e1b 02
M 12000 35
M 1209f 03
M 120a0 02
M 120a1 70
M 12140 1b
E 20 20 112233
E 20 21 112233
E 20 22 aabbcc
E 20 23 aabbcc
E 20 24 000000
E 20 29c 000000
E 20 29e 112233
E 20 29f 112233
E 21 20 000000
E 21 21 000000
E 21 22 445566
E 21 24 ddeeff
E 21 26 ddeeff
E 21 28 ddeeff
E 22 20 111111
E 22 21 223344
E 22 22 445566
E 22 23 ddeeff

// ==== build.f ====
hw/vgc_timing_pkg.sv
hw/vgc_color_pkg.sv
hw/shr_line_sequencer.sv
hw/shr_fetch_addr_counter.sv
hw/shr_palette_ram.sv
hw/shr_pixel_decoder.sv
hw/shr_video_output.sv
hw/vgc_shr_top.sv
tests/vgc_shr_asserts.sv
tests/tb_vgc_shr.sv
